//--- board_regs_pkg.sv
// register addresses, version constants, timer lengths and the status word union
package board_regs_pkg;

    // ----------------------------------------------------------
    // bank 0 register map, addr[3:0]
    // ----------------------------------------------------------
    localparam logic [3:0] REG_STATUS     = 4'd0;   // enables, relay, power, faults
    localparam logic [3:0] REG_PHYCTRL    = 4'd1;   // phy request word
    localparam logic [3:0] REG_PHYDATA    = 4'd2;   // phy read-back holder
    localparam logic [3:0] REG_TIMEOUT    = 4'd3;   // watchdog period, in ticks
    localparam logic [3:0] REG_VERSION    = 4'd4;   // hardware version, read only
    localparam logic [3:0] REG_TEMPSNS    = 4'd5;   // two 8-bit temperature readings
    localparam logic [3:0] REG_DIGIOUT    = 4'd6;   // digital outputs, masked writes
    localparam logic [3:0] REG_FW_VERSION = 4'd7;   // firmware version, read only
    localparam logic [3:0] REG_PROMSTAT   = 4'd8;   // prom interface status
    localparam logic [3:0] REG_PROMRES    = 4'd9;   // prom result word
    localparam logic [3:0] REG_DIGIN      = 4'd10;  // limits, home, dout echo, v_fault
    localparam logic [3:0] REG_SAFETY     = 4'd11;  // external safety disables
    localparam logic [3:0] REG_WDOG       = 4'd14;  // watchdog disables
    localparam logic [3:0] REG_AMPDIS     = 4'd15;  // final amp_disable

    // fixed identity words
    localparam logic [31:0] BOARD_VERSION = 32'h514c_4131;  // ascii "QLA1"
    localparam logic [31:0] FW_VERSION    = 32'h0000_0002;

    localparam int NUM_AXES = 4;            // amplifier channels on the board

    // ----------------------------------------------------------
    // safety timer lengths
    // ----------------------------------------------------------
    localparam int WDOG_TICK_BITS  = 4;     // tick every 2**4 sysclk cycles
    localparam int MV_SETTLE_TICKS = 8;     // amps held off after mv_good rises
    localparam int MV_CNT_BITS     = $clog2(MV_SETTLE_TICKS + 1);
    localparam logic [15:0] WDOG_PERIOD_RESET = 16'hffff;

    // status word as seen on reads, msb first
    typedef struct packed {
        logic [3:0]            num_chan;     // byte 3
        logic [3:0]            board_id;
        logic                  wdog_timeout; // byte 2
        logic [2:0]            zero_2;
        logic                  mv_good;
        logic                  pwr_enable;
        logic                  relay_fb;     // relay input, inverted
        logic                  relay_on;
        logic [7-NUM_AXES:0]   zero_1;       // byte 1
        logic [NUM_AXES-1:0]   fault;
        logic [7-NUM_AXES:0]   zero_0;       // byte 0
        logic [NUM_AXES-1:0]   amp_en;       // 1 = amplifier enabled
    } status_rd_t;

    // status word as a command on writes
    typedef struct packed {
        logic [11:0]           rsvd_hi;
        logic                  pwr_mask;     // bit 19
        logic                  pwr_val;      // bit 18
        logic                  relay_mask;   // bit 17
        logic                  relay_val;    // bit 16
        logic [7-NUM_AXES:0]   rsvd_1;
        logic [NUM_AXES-1:0]   en_mask;      // bits 11:8
        logic [7-NUM_AXES:0]   rsvd_0;
        logic [NUM_AXES-1:0]   en_val;       // bits 3:0
    } status_wr_t;

    typedef union packed {
        status_rd_t rd;
        status_wr_t wr;
    } status_word_u;

endpackage

//--- board_io_pkg.sv
// host request struct and the slow board input bundle
package board_io_pkg;

    import board_regs_pkg::*;

    // ----------------------------------------------------------
    // host request, one per valid/ready handshake
    // ----------------------------------------------------------
    typedef struct packed {
        logic [7:0]  addr;     // [7:4] bank, [3:0] register
        logic [31:0] wdata;    // ignored on reads
        logic        write;    // 1 = write, 0 = read
    } host_req_t;

    // ----------------------------------------------------------
    // board inputs, all slow or quasi-static
    // ----------------------------------------------------------
    typedef struct packed {
        logic [NUM_AXES-1:0] neg_limit;  // negative limit switches
        logic [NUM_AXES-1:0] pos_limit;  // positive limit switches
        logic [NUM_AXES-1:0] home;       // home sensors
        logic [NUM_AXES-1:0] fault;      // amplifier fault, 1 = amp on

        logic                relay;      // safety relay feedback, active low
        logic                mv_good;    // motor supply in range
        logic                v_fault;    // supply fault

        logic [3:0]          board_id;   // rotary switch

        // two 8-bit sensor readings side by side
        logic [15:0]         temp_sense;

        // prom interface words, passed through on reads
        logic [31:0]         prom_status;
        logic [31:0]         prom_result;

        logic [NUM_AXES-1:0] safety_amp_disable;  // from the safety chain
    } board_in_t;

    // nothing else lives here; register layout is in board_regs_pkg
    // widths above follow NUM_AXES from that package
    // the bundle is sampled directly by the register file
    // relay and mv_good feed the status word unregistered
    // safety_amp_disable is latched sticky into the disable register
    // mv_good also starts the settle timer

endpackage

//--- board_regs.sv
// host register file with masked control writes, read mux and sticky amp disables
module board_regs
    import board_regs_pkg::*;
    import board_io_pkg::*;
(
    input  logic                sysclk,
    input  logic                reset,             // sync, active low

    // host request and response channels
    input  host_req_t           req,
    input  logic                req_valid,
    output logic                req_ready,
    output logic [31:0]         rsp_rdata,
    output logic                rsp_valid,
    input  logic                rsp_ready,

    input  board_in_t           brd,

    // safety timer link
    output logic                wr_strobe,         // accepted bank 0 write
    output logic [15:0]         wdog_period,
    input  logic                wdog_timeout,
    input  logic [NUM_AXES-1:0] wdog_amp_disable,
    input  logic [NUM_AXES-1:0] mv_amp_disable,

    // board controls
    output logic [NUM_AXES-1:0] amp_disable,
    output logic [NUM_AXES-1:0] dout,
    output logic                pwr_enable,
    output logic                relay_on
);

    logic [NUM_AXES-1:0] reg_disable;    // 1 = axis disabled by host/latch
    logic [NUM_AXES-1:0] disable_nxt;
    logic [NUM_AXES-1:0] sticky;         // latched disable sources
    logic [15:0]         phy_ctrl;
    logic [15:0]         phy_data;

    logic                accept;
    logic                bank0;
    logic                status_wr;      // masked status write this cycle
    status_word_u        st_wr;          // write-side decode of wdata
    status_word_u        st_rd;          // read-side status word
    logic [NUM_AXES-1:0] dout_val;
    logic [NUM_AXES-1:0] dout_mask;
    logic [31:0]         rd_word;

    // ----------------------------------------------------------
    // handshake, one request in flight
    // ----------------------------------------------------------
    assign req_ready = ~rsp_valid;
    assign accept    = req_valid & req_ready;
    assign bank0     = (req.addr[7:4] == 4'd0);
    assign wr_strobe = accept & req.write & bank0;   // also kicks the watchdog

    assign st_wr     = req.wdata;
    assign status_wr = wr_strobe && (req.addr[3:0] == REG_STATUS);
    assign dout_val  = req.wdata[NUM_AXES-1:0];
    assign dout_mask = req.wdata[8 +: NUM_AXES];

    assign amp_disable = reg_disable | mv_amp_disable;  // settle hold on top

    // sticky latch, a masked status write wins for its own bits
    always_comb begin
        sticky      = reg_disable | wdog_amp_disable | brd.safety_amp_disable;
        disable_nxt = sticky;
        if (status_wr) begin
            disable_nxt = (sticky & ~st_wr.wr.en_mask) |
                          (~st_wr.wr.en_val & st_wr.wr.en_mask);
        end
    end

    // ----------------------------------------------------------
    // writable registers
    // ----------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            reg_disable <= '1;                // start with all amps off
            pwr_enable  <= 1'b0;
            relay_on    <= 1'b0;
            dout        <= '0;
            phy_ctrl    <= 16'd0;
            phy_data    <= 16'd0;
            wdog_period <= WDOG_PERIOD_RESET;
        end else begin
            reg_disable <= disable_nxt;
            if (wr_strobe) begin
                case (req.addr[3:0])
                    REG_STATUS: begin
                        if (st_wr.wr.relay_mask) relay_on   <= st_wr.wr.relay_val;
                        if (st_wr.wr.pwr_mask)   pwr_enable <= st_wr.wr.pwr_val;
                    end
                    REG_PHYCTRL: phy_ctrl    <= req.wdata[15:0];
                    REG_PHYDATA: phy_data    <= req.wdata[15:0];
                    REG_TIMEOUT: wdog_period <= req.wdata[15:0];
                    REG_DIGIOUT: dout <= (dout & ~dout_mask) | (dout_val & dout_mask);
                    default: ;                        // read-only or unmapped
                endcase
            end
        end
    end

    // ----------------------------------------------------------
    // read mux
    // ----------------------------------------------------------
    always_comb begin
        st_rd.rd.num_chan     = 4'(NUM_AXES);
        st_rd.rd.board_id     = brd.board_id;
        st_rd.rd.wdog_timeout = wdog_timeout;
        st_rd.rd.zero_2       = '0;
        st_rd.rd.mv_good      = brd.mv_good;
        st_rd.rd.pwr_enable   = pwr_enable;
        st_rd.rd.relay_fb     = ~brd.relay;
        st_rd.rd.relay_on     = relay_on;
        st_rd.rd.zero_1       = '0;
        st_rd.rd.fault        = brd.fault;
        st_rd.rd.zero_0       = '0;
        st_rd.rd.amp_en       = ~reg_disable;

        rd_word = 32'd0;                     // unmapped and other banks
        if (bank0) begin
            case (req.addr[3:0])
                REG_STATUS:     rd_word = st_rd;
                REG_PHYCTRL:    rd_word = {16'd0, phy_ctrl};
                REG_PHYDATA:    rd_word = {16'd0, phy_data};
                REG_TIMEOUT:    rd_word = {16'd0, wdog_period};
                REG_VERSION:    rd_word = BOARD_VERSION;
                REG_TEMPSNS:    rd_word = {16'd0, brd.temp_sense};
                REG_DIGIOUT:    rd_word = 32'(dout);
                REG_FW_VERSION: rd_word = FW_VERSION;
                REG_PROMSTAT:   rd_word = brd.prom_status;
                REG_PROMRES:    rd_word = brd.prom_result;
                REG_DIGIN:      rd_word = 32'({brd.v_fault, dout, brd.neg_limit,
                                               brd.pos_limit, brd.home});
                REG_SAFETY:     rd_word = 32'(brd.safety_amp_disable);
                REG_WDOG:       rd_word = 32'(wdog_amp_disable);
                REG_AMPDIS:     rd_word = 32'(amp_disable);
                default:        rd_word = 32'd0;
            endcase
        end
    end

    // ----------------------------------------------------------
    // response holding register
    // ----------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;               // one cycle latency
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge sysclk) begin
        if (accept) begin
            rsp_rdata <= req.write ? 32'd0 : rd_word;   // writes answer zero
        end
    end

    // stalled response must not move under back-pressure
    a_rsp_hold: assert property (@(posedge sysclk) disable iff (!reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata));

    // never two requests in flight
    a_ready_excl: assert property (@(posedge sysclk) disable iff (!reset)
        !(req_ready && rsp_valid));

endmodule

//--- safety_timers.sv
// tick prescaler, host watchdog and motor-voltage settle timer
module safety_timers
    import board_regs_pkg::*;
(
    input  logic                sysclk,
    input  logic                reset,             // sync, active low
    input  logic                wr_strobe,         // host write clears the watchdog
    input  logic [15:0]         wdog_period,       // 0 = watchdog off
    input  logic                mv_good,
    output logic                wdog_timeout,
    output logic [NUM_AXES-1:0] wdog_amp_disable,
    output logic [NUM_AXES-1:0] mv_amp_disable
);

    logic [WDOG_TICK_BITS-1:0] presc;
    logic                      tick;           // one cycle every 2**WDOG_TICK_BITS
    logic [15:0]               wdog_count;     // ticks since last host write
    logic [MV_CNT_BITS-1:0]    mv_count;       // ticks since mv_good rose
    logic                      mv_settling;

    // ----------------------------------------------------------
    // free-running prescaler
    // ----------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    assign tick = &presc;

    // ----------------------------------------------------------
    // watchdog
    // ----------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            wdog_count       <= 16'd0;
            wdog_timeout     <= 1'b0;
            wdog_amp_disable <= '0;
        end else if (wr_strobe) begin
            // host alive so start over
            wdog_count       <= 16'd0;
            wdog_timeout     <= 1'b0;
            wdog_amp_disable <= '0;
        end else if (tick && (wdog_period != 16'd0)) begin
            if (wdog_count < wdog_period) begin
                wdog_count <= wdog_count + 1'b1;
            end else begin
                wdog_timeout     <= 1'b1;    // stays until next write
                wdog_amp_disable <= '1;      // all axes off
            end
        end
    end

    // ----------------------------------------------------------
    // motor voltage settle
    // ----------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            mv_count <= '0;
        end else if (!mv_good) begin
            mv_count <= '0;                  // supply dropped so rearm
        end else if (tick && mv_settling) begin
            mv_count <= mv_count + 1'b1;     // saturates at the limit
        end
    end

    assign mv_settling = (mv_count < MV_CNT_BITS'(MV_SETTLE_TICKS));

    // hold amps off until the supply has been good long enough
    assign mv_amp_disable = {NUM_AXES{mv_good & mv_settling}};

    // watchdog disables move as one group
    a_wdog_group: assert property (@(posedge sysclk) disable iff (!reset)
        (wdog_amp_disable == '0) || (wdog_amp_disable == '1));

    // flag and disables set together
    a_timeout_dis: assert property (@(posedge sysclk) disable iff (!reset)
        wdog_timeout |-> (wdog_amp_disable == '1));

endmodule

//--- board_ctrl_top.sv
// board control top, register file plus safety timers
module board_ctrl_top
    import board_regs_pkg::*;
    import board_io_pkg::*;
(
    input  logic                sysclk,
    input  logic                reset,        // sync, active low

    // host side
    input  host_req_t           req,
    input  logic                req_valid,
    output logic                req_ready,
    output logic [31:0]         rsp_rdata,
    output logic                rsp_valid,
    input  logic                rsp_ready,

    // board side
    input  board_in_t           brd,
    output logic [NUM_AXES-1:0] amp_disable,
    output logic [NUM_AXES-1:0] dout,
    output logic                pwr_enable,
    output logic                relay_on
);

    // register file <-> timers
    logic                wr_strobe;
    logic [15:0]         wdog_period;
    logic                wdog_timeout;
    logic [NUM_AXES-1:0] wdog_amp_disable;
    logic [NUM_AXES-1:0] mv_amp_disable;

    board_regs regs (
        .sysclk           (sysclk),
        .reset            (reset),
        .req              (req),
        .req_valid        (req_valid),
        .req_ready        (req_ready),
        .rsp_rdata        (rsp_rdata),
        .rsp_valid        (rsp_valid),
        .rsp_ready        (rsp_ready),
        .brd              (brd),
        .wr_strobe        (wr_strobe),
        .wdog_period      (wdog_period),
        .wdog_timeout     (wdog_timeout),
        .wdog_amp_disable (wdog_amp_disable),
        .mv_amp_disable   (mv_amp_disable),
        .amp_disable      (amp_disable),
        .dout             (dout),
        .pwr_enable       (pwr_enable),
        .relay_on         (relay_on)
    );

    // slow timers, mv_good straight from the board bundle
    safety_timers timers (
        .sysclk           (sysclk),
        .reset            (reset),
        .wr_strobe        (wr_strobe),
        .wdog_period      (wdog_period),
        .mv_good          (brd.mv_good),
        .wdog_timeout     (wdog_timeout),
        .wdog_amp_disable (wdog_amp_disable),
        .mv_amp_disable   (mv_amp_disable)
    );

endmodule

//--- board_ctrl_tb.sv
// testbench for board_ctrl_top, plays board_ctrl_input.txt and checks reads and ports
module board_ctrl_tb
    import board_regs_pkg::*;
    import board_io_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    logic                sysclk;
    logic                reset;
    host_req_t           req;
    logic                req_valid;
    logic                req_ready;
    logic [31:0]         rsp_rdata;
    logic                rsp_valid;
    logic                rsp_ready;
    board_in_t           brd;
    logic [NUM_AXES-1:0] amp_disable;
    logic [NUM_AXES-1:0] dout;
    logic                pwr_enable;
    logic                relay_on;

    string lines[$];                  // data file, comments stripped
    int    checks, errors, test_checks, test_errors, tests;

    board_ctrl_top UUT (.*);

    initial begin
        sysclk = 1'b0;
        forever #20 sysclk = ~sysclk;  // 40 ns period
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        test_checks++;
        assert (got === exp) else begin
            $display("FAILED %s expected %h got %h", name, exp, got);
            errors++;
            test_errors++;
        end
    endtask

    task automatic set_input(input string field, input logic [31:0] v);
        case (field)
            "relay":    brd.relay = v[0];
            "mv_good":  brd.mv_good = v[0];
            "vf":       brd.v_fault = v[0];
            "board_id": brd.board_id = v[3:0];
            "fault":    brd.fault = v[3:0];
            "neg":      brd.neg_limit = v[3:0];
            "pos":      brd.pos_limit = v[3:0];
            "home":     brd.home = v[3:0];
            "safety":   brd.safety_amp_disable = v[3:0];
            "temp":     brd.temp_sense = v[15:0];
            "pstat":    brd.prom_status = v;
            "pres":     brd.prom_result = v;
            default: begin
                $display("unknown input field %s in data file", field);
                errors++;
            end
        endcase
    endtask

    // one request and its response, random rsp_ready delay
    task automatic transact(input logic [7:0] addr, input logic [31:0] wdata,
                            input logic write, output logic [31:0] rdata);
        int delay;
        @(negedge sysclk);
        while (!req_ready) @(negedge sysclk);
        req.addr  = addr;
        req.wdata = wdata;
        req.write = write;
        req_valid = 1'b1;
        @(negedge sysclk);               // accepted on the edge just passed
        req_valid = 1'b0;
        check("rsp_valid", 32'd1, 32'(rsp_valid));
        rdata = rsp_rdata;
        delay = $urandom % 4;
        repeat (delay) @(negedge sysclk);
        rsp_ready = 1'b1;
        @(negedge sysclk);
        rsp_ready = 1'b0;
    endtask

    // stalled read with a second read queued behind it
    task automatic stall_read(input logic [7:0] a1, input logic [31:0] e1,
                              input logic [7:0] a2, input logic [31:0] e2, input int stall);
        logic [31:0] held;
        @(negedge sysclk);
        req = '{addr: a1, wdata: 32'd0, write: 1'b0};
        req_valid = 1'b1;
        @(negedge sysclk);
        held = rsp_rdata;
        req.addr = a2;                   // next request waits on the bus
        repeat (stall) begin
            @(negedge sysclk);
            check("rsp_valid", 32'd1, 32'(rsp_valid));
            check("rsp_rdata", held, rsp_rdata);
            check("req_ready", 32'd0, 32'(req_ready));
        end
        check("rsp_rdata", e1, held);
        rsp_ready = 1'b1;
        @(negedge sysclk);               // first response done, second not yet taken
        rsp_ready = 1'b0;
        check("req_ready", 32'd1, 32'(req_ready));
        @(negedge sysclk);
        req_valid = 1'b0;
        check("rsp_valid", 32'd1, 32'(rsp_valid));
        check("rsp_rdata", e2, rsp_rdata);
        rsp_ready = 1'b1;
        @(negedge sysclk);
        rsp_ready = 1'b0;
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        int          fd, n, waits, ops;
        string       line, op, name;
        logic [31:0] a, b, c, d, e, rd;
        longint      limit;

        reset = 1'b0;
        req = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b0;
        brd = '0;
        void'($urandom(32'ha608));

        fd = $fopen("board_ctrl_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open board_ctrl_input.txt");
            $display("tests failed");
            $finish;
        end
        waits = 0;
        ops = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "%s", op) == 1 && op[0] != "#") begin
                lines.push_back(line);
                ops++;
                if (op == "D" && $sscanf(line, "%s %d", op, n) == 2) waits += n;
                if (op == "B" && $sscanf(line, "%s %h %h %h %h %d", op, a, b, c, d, n) == 6)
                    waits += n;
            end
        end
        $fclose(fd);

        limit = (longint'(waits) + 10 * ops + 200) * 40;   // in ns
        fork
            begin
                #(limit);
                $display("run hung, no progress before the time limit");
                $display("tests failed");
                $finish;
            end
        join_none

        repeat (3) @(posedge sysclk);    // reset held 3 cycles
        @(negedge sysclk);
        reset = 1'b1;

        foreach (lines[i]) begin
            void'($sscanf(lines[i], "%s", op));
            case (op)
                "W": begin
                    void'($sscanf(lines[i], "%s %h %h", op, a, b));
                    transact(a[7:0], b, 1'b1, rd);
                    check("rsp_rdata", 32'd0, rd);     // writes answer zero
                end
                "R": begin
                    void'($sscanf(lines[i], "%s %h %h", op, a, b));
                    transact(a[7:0], 32'd0, 1'b0, rd);
                    check("rsp_rdata", b, rd);
                end
                "S": begin
                    void'($sscanf(lines[i], "%s %s %h", op, name, a));
                    @(negedge sysclk);
                    set_input(name, a);
                end
                "D": begin
                    void'($sscanf(lines[i], "%s %d", op, n));
                    repeat (n) @(negedge sysclk);
                end
                "P": begin
                    void'($sscanf(lines[i], "%s %h %h %h %h", op, a, b, c, d));
                    @(negedge sysclk);
                    check("amp_disable", a, 32'(amp_disable));
                    check("dout", b, 32'(dout));
                    check("pwr_enable", c, 32'(pwr_enable));
                    check("relay_on", d, 32'(relay_on));
                end
                "B": begin
                    void'($sscanf(lines[i], "%s %h %h %h %h %d", op, a, b, c, e, n));
                    stall_read(a[7:0], b, c[7:0], e, n);
                end
                "T": begin
                    void'($sscanf(lines[i], "%s %s", op, name));
                    tests++;
                    $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
                    test_checks = 0;
                    test_errors = 0;
                end
                default: begin
                    $display("unknown operation in data file: %s", lines[i]);
                    errors++;
                end
            endcase
        end

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- board_ctrl_input.txt
# ops: W addr data | R addr expected | S field value | D cycles | T name
# P amp_disable dout pwr_enable relay_on | B addr1 exp1 addr2 exp2 stall_cycles
S board_id 5
S relay 1
R 00 45000000
R 04 514c4131
R 07 00000002
R 0f 0000000f
P f 0 0 0
T reset_defaults
W 00 00000a0a
P 5 0 0 0
R 00 4500000a
W 00 000d0000
P 5 0 1 0
W 00 00030000
R 00 4505000a
W 06 00000f0f
W 06 00000300
R 06 0000000c
P 5 c 1 1
T masked_writes
W 01 1234abcd
R 01 0000abcd
W 02 ffff5678
R 02 00005678
W 03 0001ffff
R 03 0000ffff
S temp 1a2b
S pstat deadbeef
S pres 0badf00d
S neg 3
S pos 9
S home 6
S vf 1
R 05 00001a2b
R 08 deadbeef
R 09 0badf00d
R 0a 0001c396
R 0b 00000000
R 0c 00000000
R 0d 00000000
R 10 00000000
R 24 00000000
W 10 0000ffff
W 13 00000005
R 00 4505000a
R 03 0000ffff
T plain_and_decode
W 03 00000003
D 100
R 00 45850000
R 0e 0000000f
R 0f 0000000f
P f c 1 1
W 01 00000000
R 0e 00000000
R 00 45050000
W 03 00000000
W 00 00000f0f
P 0 c 1 1
R 00 4505000f
S safety 4
D 2
P 4 c 1 1
S safety 0
D 2
P 4 c 1 1
R 0b 00000000
R 0f 00000004
W 00 00000404
P 0 c 1 1
T watchdog_latch
S mv_good 1
D 32
P f c 1 1
R 00 450d000f
D 160
P 0 c 1 1
R 0f 00000000
S mv_good 0
T mv_settle
B 04 514c4131 07 00000002 6
B 05 00001a2b 00 4505000f 4
T back_pressure

//--- all.f
board_regs_pkg.sv
board_io_pkg.sv
board_regs.sv
safety_timers.sv
board_ctrl_top.sv
board_ctrl_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= board_ctrl_tb
FILELIST  ?= all.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
